// File: alignAdd.sv
// Operand unpack, align and add
`timescale 1ns/100ps
`include "fpadd_consts.svh"

module alignAdd (
   input logic clk,
   input logic reset,
   fpStageIf.sink operation,
   fpStageIf.source rawSum
);

   // hidden bit, fraction, guard, round, extra and sticky
   localparam int alignW = `FPADD_MANT_W + 1;

   // one operand in the double internal format
   typedef struct packed {
      logic sign;
      logic [10:0] exp;
      logic [52:0] sig;
      logic inf;
      logic nan;
      logic snan;
   } unpackedOp;

   function automatic unpackedOp unpack(input logic [63:0] x, input logic single);
      unpackedOp u;
      logic [51:0] frac;
      logic expZero;
      logic expMax;
      frac = single ? {x[22:0], 29'd0} : x[51:0];
      expZero = single ? (x[30:23] == 8'h00) : (x[62:52] == 11'h000);
      expMax = single ? (&x[30:23]) : (&x[62:52]);
      u.sign = single ? x[31] : x[63];
      // single exponents move from bias 127 to bias 1023
      u.exp = expZero ? 11'd0 : (single ? {3'b000, x[30:23]} + 11'd896 : x[62:52]);
      // zeros and denormals both come in as zero
      u.sig = expZero ? 53'd0 : {1'b1, frac};
      u.inf = expMax && (frac == 52'd0);
      u.nan = expMax && (frac != 52'd0);
      // a signaling NaN has the top fraction bit clear
      u.snan = u.nan && !frac[51];
      return u;
   endfunction

   unpackedOp opA;
   unpackedOp opB;
   unpackedOp big;
   unpackedOp smallOp;
   logic effSub;
   logic [10:0] expDiff;
   logic [5:0] shiftAmt;
   logic [alignW+62:0] shiftWide;
   logic [alignW-1:0] smallAligned;
   logic [alignW:0] magnitude;
   logic infMinusInf;
   logic isNaN;
   logic isInf;
   logic resultSign;
   fpAddPkg::fpRawSum rawNext;

   always_comb begin
      opA = unpack(operation.payload.opA, operation.singlePrecision);
      opB = unpack(operation.payload.opB, operation.singlePrecision);
      // subtracting is adding the second operand with its sign flipped
      opB.sign = opB.sign ^ operation.payload.subtract;
      effSub = opA.sign ^ opB.sign;
      // the larger magnitude goes first so a difference never goes negative
      if ({opB.exp, opB.sig} > {opA.exp, opA.sig}) begin
         big = opB;
         smallOp = opA;
      end else begin
         big = opA;
         smallOp = opB;
      end
      expDiff = big.exp - smallOp.exp;
      // past 63 places the smaller operand is all sticky so the shift saturates
      shiftAmt = (expDiff > 11'd63) ? 6'd63 : expDiff[5:0];
      shiftWide = {smallOp.sig, 4'd0, 63'd0} >> shiftAmt;
      // everything shifted below the sticky position is ORed into it
      smallAligned = {shiftWide[alignW+62:64], shiftWide[63] | (|shiftWide[62:0])};
      if (effSub) begin
         magnitude = {1'b0, big.sig, 4'd0} - {1'b0, smallAligned};
      end else begin
         magnitude = {1'b0, big.sig, 4'd0} + {1'b0, smallAligned};
      end

      infMinusInf = opA.inf && opB.inf && effSub;
      isNaN = opA.nan || opB.nan || infMinusInf;
      isInf = opA.inf || opB.inf;

      // an infinity keeps its own sign
      if (isInf) begin
         resultSign = opA.inf ? opA.sign : opB.sign;
      end else if (magnitude == '0) begin
         // an exact zero from opposite signs is positive except toward minus
         resultSign = effSub ? (operation.rm == fpAddPkg::rmTowardMinus) : opA.sign;
      end else begin
         resultSign = big.sign;
      end

      rawNext.sign = resultSign;
      rawNext.exponent = {1'b0, big.exp};
      rawNext.magnitude = magnitude;
      if (isNaN) begin
         rawNext.specialKind = fpAddPkg::skNaN;
      end else if (isInf) begin
         rawNext.specialKind = fpAddPkg::skInfinity;
      end else begin
         rawNext.specialKind = fpAddPkg::skNone;
      end
      rawNext.invalid = opA.snan || opB.snan || infMinusInf;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rawSum.valid <= 1'b0;
      end else begin
         rawSum.valid <= operation.valid;
      end
   end

   always_ff @(posedge clk) begin
      rawSum.payload <= rawNext;
      rawSum.rm <= operation.rm;
      rawSum.singlePrecision <= operation.singlePrecision;
   end

endmodule

// File: fpAddPkg.sv
// FP adder shared types
`include "fpadd_consts.svh"

package fpAddPkg;

   // rounding modes in the encoding of the rm field
   typedef enum logic [1:0] {
      rmNearestEven = 2'b00,
      rmTowardZero = 2'b01,
      rmTowardPlus = 2'b10,
      rmTowardMinus = 2'b11
   } roundMode;

   // special results decided ahead of the rounder
   typedef enum logic [1:0] {
      skNone = 2'b00,
      skInfinity = 2'b01,
      skNaN = 2'b10,
      skExactZero = 2'b11
   } fpSpecial;

   // one queue entry with single operands held in the low 32 bits
   typedef struct packed {
      logic [63:0] opA;
      logic [63:0] opB;
      logic subtract;
      logic singlePrecision;
      roundMode rm;
   } fpOperation;

   // magnitude holds carry, hidden bit, fraction, guard, round, extra and sticky
   typedef struct packed {
      logic sign;
      logic [`FPADD_EXP_W-1:0] exponent;
      logic [`FPADD_MANT_W+1:0] magnitude;
      fpSpecial specialKind;
      logic invalid;
   } fpRawSum;

   // the leading one sits in the top bit and bit 0 carries the sticky
   typedef struct packed {
      logic sign;
      logic [`FPADD_EXP_W-1:0] exponent;
      logic [`FPADD_MANT_W-1:0] significand;
      fpSpecial specialKind;
      logic invalid;
   } fpNormSum;

   // IEEE exception flags
   typedef struct packed {
      logic underflow;
      logic overflow;
      logic divByZero;
      logic invalid;
      logic inexact;
   } fpFlags;

endpackage

// File: fpAddTb.sv
// FP adder testbench
`timescale 1ns/100ps
`include "fpadd_consts.svh"

module fpAddTb;

   localparam int clkPeriod = 40;
   localparam int numOps = 3000;
   localparam int queueDepth = `FPADD_QUEUE_DEPTH;
   localparam int resultSlots = `FPADD_RESULT_CREDITS;
   // exact bits kept below the LSB by the model with the lowest one as a sticky
   localparam int guardBits = 6;

   logic clk;
   logic reset;
   logic opValid;
   logic [63:0] opA;
   logic [63:0] opB;
   logic opSubtract;
   logic opSinglePrecision;
   fpAddPkg::roundMode opRoundMode;
   logic opCredit;
   logic [63:0] result;
   logic [4:0] flags;
   logic resultValid;
   logic resultCredit;

   integer seed;
   int cycle;
   int sent;
   int received;
   int credits;
   int granted;
   int creditPulses;

   // expected results in issue order and the cycle of each opCredit pulse
   logic [63:0] expResults[$];
   logic [4:0] expFlags[$];
   int creditCycles[$];

   fpAddTop i_fpAddTop (
      .clk(clk),
      .reset(reset),
      .opValid(opValid),
      .opA(opA),
      .opB(opB),
      .opSubtract(opSubtract),
      .opSinglePrecision(opSinglePrecision),
      .opRoundMode(opRoundMode),
      .opCredit(opCredit),
      .result(result),
      .flags(flags),
      .resultValid(resultValid),
      .resultCredit(resultCredit)
   );

   always #(clkPeriod / 2) clk = ~clk;

   task automatic failRun(input string what);
      $display("%s", what);
      $display("Test failed");
      $fatal(1, "simulation stopped at %0t", $time);
   endtask

   // the run is bounded at 20 cycles per operation
   initial begin
      #(numOps * 20 * clkPeriod);
      failRun("timeout: not all results arrived within the cycle budget");
   end

   // kind picks zero, denormal, infinity, NaN, high, low, near expNear or any exponent
   task automatic makeOperand(input logic sp, input int kind, input int expNear,
                              output logic [63:0] x);
      logic [63:0] frac;
      logic [31:0] upper;
      logic sign;
      int emax;
      int fracW;
      int e;
      emax = sp ? 255 : 2047;
      fracW = sp ? 23 : 52;
      frac = {$random(seed), $random(seed)};
      frac = frac & ((64'd1 << fracW) - 1);
      upper = $random(seed);
      sign = 1'($random(seed));
      case (kind)
         0: begin
            e = 0;
            frac = '0;
         end
         1: e = 0;
         2: begin
            e = emax;
            frac = '0;
         end
         // the top fraction bit stays random so both quiet and signaling NaNs appear
         3: begin
            e = emax;
            frac[0] = 1'b1;
         end
         4, 5: e = emax - 1 - ($random(seed) & 3);
         6, 7: e = 1 + ($random(seed) & 3);
         8: e = expNear + $random(seed) % 4;
         default: e = 1 + {$random(seed)} % (emax - 1);
      endcase
      if (kind >= 4) begin
         e = (e < 1) ? 1 : ((e > emax - 1) ? emax - 1 : e);
      end
      // upper word of a single operand is junk that the DUT must ignore
      x = sp ? {upper, sign, 8'(e), frac[22:0]} : {sign, 11'(e), frac[51:0]};
   endtask

   // IEEE add in the operand's own format with flush to zero at both ends
   task automatic computeExpected(input logic [63:0] a, input logic [63:0] b,
                                  input logic sub, input logic sp, input logic [1:0] rm,
                                  output logic [63:0] res, output logic [4:0] flg);
      int fracW, emax, hidden, ea, eb, eBig, d, e, lead, i;
      logic sa, sb, sBig, effSub, infA, infB, nanA, nanB, invalid;
      logic [63:0] fa, fb, ma, mb, mBig, mSmall, aligned, sum, kept, fracOut;
      logic lsb, rnd, stk, up, towardZero, ovf, unf, signOut;
      logic [10:0] expOut;
      fracW = sp ? 23 : 52;
      emax = sp ? 255 : 2047;
      hidden = fracW + guardBits;
      sa = sp ? a[31] : a[63];
      sb = (sp ? b[31] : b[63]) ^ sub;
      ea = sp ? a[30:23] : a[62:52];
      eb = sp ? b[30:23] : b[62:52];
      fa = sp ? {41'd0, a[22:0]} : {12'd0, a[51:0]};
      fb = sp ? {41'd0, b[22:0]} : {12'd0, b[51:0]};
      effSub = sa ^ sb;
      infA = (ea == emax) && (fa == 0);
      infB = (eb == emax) && (fb == 0);
      nanA = (ea == emax) && (fa != 0);
      nanB = (eb == emax) && (fb != 0);
      invalid = (nanA && !fa[fracW-1]) || (nanB && !fb[fracW-1]) || (infA && infB && effSub);
      // a zero exponent field means zero whatever the fraction holds
      ma = (ea == 0) ? 64'd0 : ((64'd1 << fracW) | fa) << guardBits;
      mb = (eb == 0) ? 64'd0 : ((64'd1 << fracW) | fb) << guardBits;
      flg = {3'b000, invalid, 1'b0};
      signOut = 1'b0;
      expOut = '0;
      fracOut = '0;
      if (nanA || nanB || (infA && infB && effSub)) begin
         expOut = 11'(emax);
         fracOut = 64'd1 << (fracW - 1);
      end else if (infA || infB) begin
         signOut = infA ? sa : sb;
         expOut = 11'(emax);
      end else begin
         if ((eb > ea) || ((eb == ea) && (mb > ma))) begin
            sBig = sb;
            eBig = eb;
            mBig = mb;
            mSmall = ma;
            d = eb - ea;
         end else begin
            sBig = sa;
            eBig = ea;
            mBig = ma;
            mSmall = mb;
            d = ea - eb;
         end
         // bits that fall off the smaller operand are jammed into the LSB
         if (d > 62) begin
            aligned = {63'd0, mSmall != 0};
         end else begin
            aligned = (mSmall >> d) | {63'd0, (mSmall & ((64'd1 << d) - 1)) != 0};
         end
         sum = effSub ? mBig - aligned : mBig + aligned;
         if (sum == 0) begin
            signOut = effSub ? (rm == 2'b11) : sa;
         end else begin
            lead = 0;
            for (i = 0; i < 64; i++) begin
               if (sum[i]) begin
                  lead = i;
               end
            end
            e = eBig;
            if (lead > hidden) begin
               sum = (sum >> 1) | {63'd0, sum[0]};
               e = e + 1;
            end else begin
               sum = sum << (hidden - lead);
               e = e - (hidden - lead);
            end
            lsb = sum[guardBits];
            rnd = sum[guardBits-1];
            stk = (sum & ((64'd1 << (guardBits - 1)) - 1)) != 0;
            towardZero = (rm == 2'b01) || ((rm == 2'b10) && sBig) || ((rm == 2'b11) && !sBig);
            case (rm)
               2'b00: up = rnd && (lsb || stk);
               2'b10: up = !sBig && (rnd || stk);
               2'b11: up = sBig && (rnd || stk);
               default: up = 1'b0;
            endcase
            kept = (sum >> guardBits) + {63'd0, up};
            if (kept[fracW+1]) begin
               kept = kept >> 1;
               e = e + 1;
            end
            // range is checked on the rounded exponent
            ovf = e >= emax;
            unf = e <= 0;
            signOut = sBig;
            if (ovf) begin
               expOut = towardZero ? 11'(emax - 1) : 11'(emax);
               fracOut = towardZero ? (64'd1 << fracW) - 1 : 64'd0;
            end else if (!unf) begin
               expOut = 11'(e);
               fracOut = kept;
            end
            flg = {unf, ovf, 1'b0, 1'b0, rnd || stk || ovf || unf};
         end
      end
      res = sp ? {32'hFFFF_FFFF, signOut, expOut[7:0], fracOut[22:0]}
               : {signOut, expOut, fracOut[51:0]};
   endtask

   // B repeats A for cancellation, sits near A's exponent, or is drawn on its own
   task automatic sendOperation();
      logic [63:0] a, b, res;
      logic [4:0] flg;
      logic sp, sub;
      logic [1:0] rm;
      int kindA, expA;
      sp = ({$random(seed)} % 3) == 0;
      sub = 1'($random(seed));
      rm = 2'($random(seed));
      kindA = {$random(seed)} % 11;
      if (kindA == 8) begin
         kindA = 9;
      end
      makeOperand(sp, kindA, 0, a);
      expA = sp ? a[30:23] : a[62:52];
      case ($random(seed) & 3)
         0: b = a;
         1: makeOperand(sp, 8, expA, b);
         default: makeOperand(sp, {$random(seed)} % 11, expA, b);
      endcase
      computeExpected(a, b, sub, sp, rm, res, flg);
      expResults.push_back(res);
      expFlags.push_back(flg);
      opA = a;
      opB = b;
      opSubtract = sub;
      opSinglePrecision = sp;
      opRoundMode = fpAddPkg::roundMode'(rm);
      opValid = 1'b1;
   endtask

   // outputs are registered so they are stable at the falling edge
   task automatic checkOutputs();
      int creditAt;
      logic [63:0] res;
      logic [4:0] flg;
      if (opCredit) begin
         creditPulses++;
         credits++;
         creditCycles.push_back(cycle);
         assert (creditPulses <= sent)
         else failRun("opCredit pulsed with no operation waiting in the queue");
      end
      if (resultValid) begin
         assert (expResults.size() > 0 && creditCycles.size() > 0)
         else failRun("resultValid arrived with no operation issued");
         assert (granted > 0)
         else failRun("resultValid arrived while the consumer held no granted credit");
         granted--;
         // issue is one cycle before the opCredit pulse and three before the result
         creditAt = creditCycles.pop_front();
         assert (cycle == creditAt + 2)
         else failRun($sformatf("error: time %0t resultValid cycle expected %0d got %0d",
                                $time, creditAt + 2, cycle));
         res = expResults.pop_front();
         flg = expFlags.pop_front();
         assert (result === res)
         else failRun($sformatf("error: time %0t result expected %h got %h",
                                $time, res, result));
         assert (flags === flg)
         else failRun($sformatf("error: time %0t flags expected %b got %b",
                                $time, flg, flags));
         received++;
      end
   endtask

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      opValid = 1'b0;
      opA = '0;
      opB = '0;
      opSubtract = 1'b0;
      opSinglePrecision = 1'b0;
      opRoundMode = fpAddPkg::rmNearestEven;
      resultCredit = 1'b0;
      seed = 11;
      cycle = 0;
      sent = 0;
      received = 0;
      credits = queueDepth;
      granted = resultSlots;
      creditPulses = 0;
      repeat (10) begin
         @(negedge clk);
         assert (opCredit === 1'b0 && resultValid === 1'b0)
         else failRun("opCredit or resultValid was active during reset");
      end
      reset = 1'b0;
      while (received < numOps) begin
         @(negedge clk);
         cycle++;
         checkOutputs();
         opValid = 1'b0;
         if (sent < numOps && credits > 0 && ($random(seed) & 3) != 0) begin
            sendOperation();
            credits--;
            sent++;
         end
         // the consumer alternates between slow and fast phases of 128 cycles
         resultCredit = 1'b0;
         if (granted < resultSlots) begin
            if (((cycle / 128) % 2 == 1) ? (($random(seed) & 7) == 0)
                                         : (($random(seed) & 7) != 0)) begin
               resultCredit = 1'b1;
               granted++;
            end
         end
      end
      opValid = 1'b0;
      resultCredit = 1'b0;
      // a few idle cycles catch any stray pulse after the last result
      repeat (8) begin
         @(negedge clk);
         cycle++;
         checkOutputs();
      end
      assert (creditPulses == sent)
      else failRun($sformatf("error: time %0t opCredit pulses expected %0d got %0d",
                             $time, sent, creditPulses));
      $display("Test passed");
      $finish;
   end

endmodule

// File: fpAddTop.sv
// Floating-point adder top
`timescale 1ns/100ps

module fpAddTop (
   input logic clk,
   input logic reset,
   input logic opValid,
   input logic [63:0] opA,
   input logic [63:0] opB,
   input logic opSubtract,
   input logic opSinglePrecision,
   input fpAddPkg::roundMode opRoundMode,
   output logic opCredit,
   output logic [63:0] result,
   output logic [4:0] flags,
   output logic resultValid,
   input logic resultCredit
);

   // one link per pipeline boundary with its own payload
   fpStageIf #(.payloadType(fpAddPkg::fpOperation)) issueLink ();
   fpStageIf #(.payloadType(fpAddPkg::fpRawSum)) rawLink ();
   fpStageIf #(.payloadType(fpAddPkg::fpNormSum)) normLink ();

   // queue entry gathered from the plain operand ports
   fpAddPkg::fpOperation opData;

   assign opData = {opA, opB, opSubtract, opSinglePrecision, opRoundMode};

   opQueue i_opQueue (
      .clk(clk),
      .reset(reset),
      .opValid(opValid),
      .opData(opData),
      .opCredit(opCredit),
      .resultCredit(resultCredit),
      .issue(issueLink.source)
   );

   alignAdd i_alignAdd (
      .clk(clk),
      .reset(reset),
      .operation(issueLink.sink),
      .rawSum(rawLink.source)
   );

   normalizer i_normalizer (
      .clk(clk),
      .reset(reset),
      .rawSum(rawLink.sink),
      .normSum(normLink.source)
   );

   rounder i_rounder (
      .clk(clk),
      .reset(reset),
      .normSum(normLink.sink),
      .result(result),
      .flags(flags),
      .resultValid(resultValid)
   );

endmodule

// File: fpStageIf.sv
// Pipeline stage link
`timescale 1ns/100ps

interface fpStageIf #(
   parameter type payloadType = logic
);

   // a sink has no stall and takes every beat with valid high
   logic valid;
   payloadType payload;

   // rounding mode and precision travel with each operation
   fpAddPkg::roundMode rm;
   logic singlePrecision;

   modport source (
      output valid,
      output payload,
      output rm,
      output singlePrecision
   );

   modport sink (
      input valid,
      input payload,
      input rm,
      input singlePrecision
   );

endinterface

// File: fpadd_consts.svh
// FP adder constants
`ifndef FPADD_CONSTS_SVH
`define FPADD_CONSTS_SVH

// operation queue entries and the producer's starting credit count
`define FPADD_QUEUE_DEPTH 4

// result slots granted by the consumer after reset
`define FPADD_RESULT_CREDITS 4

// internal exponent is the 11-bit double field plus a sign bit for underflow
`define FPADD_EXP_W 12

// hidden bit, 52 fraction bits and three bits below the double LSB
`define FPADD_MANT_W 56

`endif

// File: normalizer.sv
// Sum normalization
`timescale 1ns/100ps
`include "fpadd_consts.svh"

module normalizer (
   input logic clk,
   input logic reset,
   fpStageIf.sink rawSum,
   fpStageIf.source normSum
);

   // the magnitude without its carry bit
   localparam int workW = `FPADD_MANT_W + 1;
   localparam int expW = `FPADD_EXP_W;

   // position of the first one from the top or workW when there is none
   function automatic logic [5:0] leadingZeros(input logic [workW-1:0] value);
      logic [5:0] count;
      logic found;
      count = 6'(workW);
      found = 1'b0;
      for (int i = workW - 1; i >= 0; i--) begin
         if (!found && value[i]) begin
            count = 6'(workW - 1 - i);
            found = 1'b1;
         end
      end
      return count;
   endfunction

   logic carry;
   logic [workW-1:0] upper;
   logic [5:0] lzc;
   logic [workW-1:0] work;
   logic [expW-1:0] expAdjusted;
   fpAddPkg::fpNormSum normNext;

   always_comb begin
      carry = rawSum.payload.magnitude[workW];
      upper = rawSum.payload.magnitude[workW-1:0];
      lzc = leadingZeros(upper);
      if (carry) begin
         // one place to the right and the bit that drops joins the sticky
         work = {rawSum.payload.magnitude[workW:2], |rawSum.payload.magnitude[1:0]};
         expAdjusted = rawSum.payload.exponent + 1'b1;
      end else begin
         // cancellation is undone by moving the first one to the top
         work = upper << lzc;
         expAdjusted = rawSum.payload.exponent - expW'(lzc);
      end

      normNext.sign = rawSum.payload.sign;
      normNext.exponent = expAdjusted;
      // the lowest two bits fold into one sticky position
      normNext.significand = {work[workW-1:2], work[1] | work[0]};
      normNext.invalid = rawSum.payload.invalid;
      if (rawSum.payload.specialKind != fpAddPkg::skNone) begin
         normNext.specialKind = rawSum.payload.specialKind;
      end else if (rawSum.payload.magnitude == '0) begin
         normNext.specialKind = fpAddPkg::skExactZero;
      end else begin
         normNext.specialKind = fpAddPkg::skNone;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         normSum.valid <= 1'b0;
      end else begin
         normSum.valid <= rawSum.valid;
      end
   end

   always_ff @(posedge clk) begin
      normSum.payload <= normNext;
      normSum.rm <= rawSum.rm;
      normSum.singlePrecision <= rawSum.singlePrecision;
   end

   // an ordinary number reaches the rounder with its leading one in place
   leadingOne: assert property (@(posedge clk) disable iff (reset)
      normSum.valid && (normSum.payload.specialKind == fpAddPkg::skNone)
      |-> normSum.payload.significand[`FPADD_MANT_W-1]);

endmodule

// File: opQueue.sv
// Operation queue and result credits
`timescale 1ns/100ps
`include "fpadd_consts.svh"

module opQueue (
   input logic clk,
   input logic reset,
   input logic opValid,
   input fpAddPkg::fpOperation opData,
   output logic opCredit,
   input logic resultCredit,
   fpStageIf.source issue
);

   localparam int depth = `FPADD_QUEUE_DEPTH;
   localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
   localparam int countW = $clog2(depth + 1);
   localparam int creditW = $clog2(`FPADD_RESULT_CREDITS + 1);

   fpAddPkg::fpOperation entries [depth];
   logic [ptrW-1:0] wrPtr;
   logic [ptrW-1:0] rdPtr;
   logic [countW-1:0] count;
   logic [creditW-1:0] resultCredits;
   logic issuing;

   // pointers wrap explicitly so the depth need not be a power of two
   function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
      return (ptr == ptrW'(depth - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // the head entry leaves only when a result slot can be reserved for it
   assign issuing = (count != '0) && (resultCredits != '0);

   assign issue.valid = issuing;
   assign issue.payload = entries[rdPtr];
   assign issue.rm = entries[rdPtr].rm;
   assign issue.singlePrecision = entries[rdPtr].singlePrecision;

   always_ff @(posedge clk) begin
      if (opValid) begin
         entries[wrPtr] <= opData;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
         resultCredits <= creditW'(`FPADD_RESULT_CREDITS);
         opCredit <= 1'b0;
      end else begin
         if (opValid) begin
            wrPtr <= nextPtr(wrPtr);
         end
         if (issuing) begin
            rdPtr <= nextPtr(rdPtr);
         end
         count <= count + countW'(opValid) - countW'(issuing);
         // a slot is taken at issue and comes back with the consumer's pulse
         resultCredits <= resultCredits + creditW'(resultCredit) - creditW'(issuing);
         // freeing the head entry hands one credit back to the producer
         opCredit <= issuing;
      end
   end

   // the producer spends a credit per push so a full queue never sees one
   noPushWhenFull: assert property (@(posedge clk) disable iff (reset)
      opValid |-> count < countW'(depth));

   // the consumer never returns more slots than it granted
   creditBound: assert property (@(posedge clk) disable iff (reset)
      resultCredits <= creditW'(`FPADD_RESULT_CREDITS));

endmodule

// File: rounder.sv
// Rounding and result packing
`timescale 1ns/100ps
`include "fpadd_consts.svh"

module rounder (
   input logic clk,
   input logic reset,
   fpStageIf.sink normSum,
   output logic [63:0] result,
   output fpAddPkg::fpFlags flags,
   output logic resultValid
);

   localparam int mantW = `FPADD_MANT_W;
   // one bit wider than the stage exponent so a rounding carry cannot wrap
   localparam int roundExpW = `FPADD_EXP_W + 1;

   // single results keep the upper word all ones
   function automatic logic [63:0] pack(input logic s, input logic [10:0] e,
                                        input logic [51:0] f, input logic single);
      return single ? {32'hFFFF_FFFF, s, e[7:0], f[51:29]} : {s, e, f};
   endfunction

   logic sp;
   logic sign;
   logic [mantW-1:0] sig;
   logic lsb;
   logic roundBit;
   logic sticky;
   logic addOne;
   logic towardZero;
   logic [53:0] increment;
   logic [53:0] rounded;
   logic signed [roundExpW-1:0] expRound;
   logic overflow;
   logic underflow;
   logic ordinary;
   logic signOut;
   logic [10:0] expField;
   logic [51:0] fracField;
   fpAddPkg::fpFlags flagsNext;

   assign sp = normSum.singlePrecision;
   assign sign = normSum.payload.sign;
   assign sig = normSum.payload.significand;

   // the single LSB sits 29 places above the double LSB
   assign lsb = sp ? sig[32] : sig[3];
   assign roundBit = sp ? sig[31] : sig[2];
   assign sticky = sp ? (|sig[30:0]) : (|sig[1:0]);

   always_comb begin
      case (normSum.rm)
         fpAddPkg::rmNearestEven: addOne = roundBit && (lsb || sticky);
         // directed modes round up in magnitude only when the sign points their way
         fpAddPkg::rmTowardPlus: addOne = !sign && (roundBit || sticky);
         fpAddPkg::rmTowardMinus: addOne = sign && (roundBit || sticky);
         default: addOne = 1'b0;
      endcase
   end

   // true when the mode truncates toward zero for this sign
   assign towardZero = (normSum.rm == fpAddPkg::rmTowardZero) ||
                       ((normSum.rm == fpAddPkg::rmTowardPlus) && sign) ||
                       ((normSum.rm == fpAddPkg::rmTowardMinus) && !sign);

   assign increment = sp ? {24'd0, addOne, 29'd0} : {53'd0, addOne};
   assign rounded = {1'b0, sig[mantW-1:3]} + increment;

   // a carry leaves the kept fraction all zeros so only the exponent moves
   assign expRound = {normSum.payload.exponent[`FPADD_EXP_W-1], normSum.payload.exponent}
                     + roundExpW'(rounded[53]);

   // the double range is 1 to 2046 and single is 897 to 1150 after rebias
   assign overflow = sp ? (expRound >= 13'sd1151) : (expRound >= 13'sd2047);
   assign underflow = sp ? (expRound <= 13'sd896) : (expRound <= 13'sd0);

   always_comb begin
      ordinary = 1'b0;
      signOut = sign;
      expField = sp ? (expRound[10:0] - 11'd896) : expRound[10:0];
      fracField = rounded[51:0];
      case (normSum.payload.specialKind)
         fpAddPkg::skNaN: begin
            // canonical quiet NaN
            signOut = 1'b0;
            expField = 11'h7FF;
            fracField = {1'b1, 51'd0};
         end
         fpAddPkg::skInfinity: begin
            expField = 11'h7FF;
            fracField = 52'd0;
         end
         fpAddPkg::skExactZero: begin
            expField = 11'h000;
            fracField = 52'd0;
         end
         default: begin
            ordinary = 1'b1;
            if (overflow) begin
               // largest finite value when the mode rounds toward zero
               expField = towardZero ? 11'h7FE : 11'h7FF;
               fracField = {52{towardZero}};
            end else if (underflow) begin
               // flushed to a zero of the same sign
               expField = 11'h000;
               fracField = 52'd0;
            end
         end
      endcase

      flagsNext.underflow = ordinary && underflow;
      flagsNext.divByZero = 1'b0;
      flagsNext.overflow = ordinary && overflow;
      flagsNext.invalid = normSum.payload.invalid;
      flagsNext.inexact = ordinary && (roundBit || sticky || overflow || underflow);
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         resultValid <= 1'b0;
      end else begin
         resultValid <= normSum.valid;
      end
   end

   always_ff @(posedge clk) begin
      result <= pack(signOut, expField, fracField, sp);
      flags <= flagsNext;
   end

endmodule

// File: verilog.f
+incdir+.
fpAddPkg.sv
fpStageIf.sv
opQueue.sv
alignAdd.sv
normalizer.sv
rounder.sv
fpAddTop.sv
fpAddTb.sv
